/* commit_trace_defines.svh */
// Widths, port count, queue depth and credit count of the commit trace monitor
`ifndef COMMIT_TRACE_DEFINES_SVH
`define COMMIT_TRACE_DEFINES_SVH

// --------------------
// Data widths
// --------------------
// PC and cause width
`define XLEN 64
// Instruction word width
`define INSN_W 32

// --------------------
// Structure
// --------------------
`define NR_COMMIT_PORTS 2
// Must hold a port index
`define PORT_IDX_W 1
// Entries in each per-port queue
`define TRACE_QUEUE_DEPTH 4
// Credits owned by the sender after reset
`define TRACE_CREDITS 4

`endif

/* commit_pkg.sv */
// Package with the commit port entry, the commit bus and the acknowledge vector
`include "commit_trace_defines.svh"

package commit_pkg;

  // --------------------
  // Commit port entry
  // --------------------
  // One committed instruction as the core hands it over
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`INSN_W-1:0] insn;
    // Set when the entry carries a trap
    logic               ex_valid;
    // MSB set marks an interrupt
    logic [`XLEN-1:0]   cause;
  } commit_entry_t;

  // --------------------
  // Port vectors
  // --------------------
  // All commit ports, port 0 in the low slot
  typedef commit_entry_t [`NR_COMMIT_PORTS-1:0] commit_bus_t;

  // Acknowledge per port, an entry counts only when its bit is set
  typedef logic [`NR_COMMIT_PORTS-1:0] commit_ack_t;

endpackage

/* trace_pkg.sv */
// Package with the trace record kind, the trace record and the control-flow flags
`include "commit_trace_defines.svh"

package trace_pkg;

  // --------------------
  // Record kind
  // --------------------
  typedef enum logic [1:0] {
    TRACE_RETIRE    = 2'd0,
    TRACE_EXCEPTION = 2'd1,
    TRACE_INTERRUPT = 2'd2
  } trace_kind_e;

  // --------------------
  // Trace record
  // --------------------
  // Tagged with the commit port it came from
  typedef struct packed {
    logic [`PORT_IDX_W-1:0] port;
    trace_kind_e            kind;
    logic [`XLEN-1:0]       pc;
    logic [`INSN_W-1:0]     insn;
    logic [`XLEN-1:0]       cause;
  } trace_rec_t;

  // --------------------
  // Control-flow flags
  // --------------------
  // One bit per port, pulsed for retired instructions only
  typedef struct packed {
    logic [`NR_COMMIT_PORTS-1:0] jalr;
    logic [`NR_COMMIT_PORTS-1:0] nop;
  } cfi_flags_t;

endpackage

/* commit_classify.sv */
// Classify stage: per-port trace record build, kind decode and JALR/NOP detection
`timescale 1ns/1ps
`include "commit_trace_defines.svh"

module commit_classify (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  commit_pkg::commit_bus_t                      commit_i,
  input  commit_pkg::commit_ack_t                      commit_ack_i,
  output logic [`NR_COMMIT_PORTS-1:0]                  push_o,
  output trace_pkg::trace_rec_t [`NR_COMMIT_PORTS-1:0] rec_o,
  output trace_pkg::cfi_flags_t                        cfi_o
);

  // Encodings watched on retired instructions
  localparam logic [6:0]         OpcodeJalr = 7'b1100111;
  localparam logic [`INSN_W-1:0] InsnNop    = 32'h00000013;

  logic [`NR_COMMIT_PORTS-1:0]                  push_d, push_q;
  trace_pkg::trace_rec_t [`NR_COMMIT_PORTS-1:0] rec_d, rec_q;
  trace_pkg::cfi_flags_t                        cfi_d, cfi_q;

  // --------------------
  // Classification
  // --------------------
  always_comb begin
    push_d = '0;
    rec_d  = '0;
    cfi_d  = '0;
    for (int i = 0; i < `NR_COMMIT_PORTS; i++) begin
      rec_d[i].port  = i[`PORT_IDX_W-1:0];
      rec_d[i].pc    = commit_i[i].pc;
      rec_d[i].insn  = commit_i[i].insn;
      rec_d[i].cause = commit_i[i].cause;

      // Trap with cause MSB set is an interrupt
      if (!commit_i[i].ex_valid) begin
        rec_d[i].kind = trace_pkg::TRACE_RETIRE;
      end else if (commit_i[i].cause[`XLEN-1]) begin
        rec_d[i].kind = trace_pkg::TRACE_INTERRUPT;
      end else begin
        rec_d[i].kind = trace_pkg::TRACE_EXCEPTION;
      end

      push_d[i] = commit_ack_i[i];

      // Flags only for acknowledged entries that actually retired
      if (commit_ack_i[i] && !commit_i[i].ex_valid) begin
        cfi_d.jalr[i] = (commit_i[i].insn[6:0] == OpcodeJalr);
        cfi_d.nop[i]  = (commit_i[i].insn == InsnNop);
      end
    end
  end

  // --------------------
  // Stage registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q <= '0;
      cfi_q  <= '0;
    end else begin
      push_q <= push_d;
      cfi_q  <= cfi_d;
    end
  end

  // Record payload, qualified by push_q
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `NR_COMMIT_PORTS; i++) begin
      if (push_d[i]) begin
        rec_q[i] <= rec_d[i];
      end
    end
  end

  assign push_o = push_q;
  assign rec_o  = rec_q;
  assign cfi_o  = cfi_q;

endmodule

/* trace_queue.sv */
// Per-port trace record FIFO with drop on full and sticky overflow flag
`timescale 1ns/1ps
`include "commit_trace_defines.svh"

module trace_queue #(
  parameter int unsigned Depth = `TRACE_QUEUE_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  trace_pkg::trace_rec_t rec_i,
  input  logic                  pop_i,
  output trace_pkg::trace_rec_t rec_o,
  output logic                  not_empty_o,
  output logic                  overflow_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  trace_pkg::trace_rec_t mem_q [Depth];
  logic [PtrW-1:0]       wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]       count_q;
  logic                  full, do_push, do_pop, overflow_q;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count_q == CntW'(Depth));
  assign not_empty_o = (count_q != '0);
  assign do_pop      = pop_i & not_empty_o;
  // A pop in the same cycle frees the slot
  assign do_push     = push_i & (~full | do_pop);

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Dropped record, stays set until reset
      if (push_i && !do_push) overflow_q <= 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  assign rec_o      = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

/* trace_merge.sv */
// Round-robin merge of the trace queues with credit counter and output register
`timescale 1ns/1ps
`include "commit_trace_defines.svh"

module trace_merge (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  trace_pkg::trace_rec_t [`NR_COMMIT_PORTS-1:0] rec_i,
  input  logic [`NR_COMMIT_PORTS-1:0]                  not_empty_i,
  input  logic [`NR_COMMIT_PORTS-1:0]                  overflow_i,
  output logic [`NR_COMMIT_PORTS-1:0]                  pop_o,
  input  logic                                         credit_return_i,
  output trace_pkg::trace_rec_t                        trace_o,
  output logic                                         trace_valid_o,
  output logic                                         overflow_o
);

  localparam int unsigned NrPorts = `NR_COMMIT_PORTS;
  localparam int unsigned CreditW = $clog2(`TRACE_CREDITS + 1);

  logic [CreditW-1:0]     credit_q, credit_d;
  logic [`PORT_IDX_W-1:0] last_q, gnt_idx;
  logic                   gnt_valid, credit_avail, grant;
  trace_pkg::trace_rec_t  trace_q;
  logic                   trace_valid_q;

  // --------------------
  // Credits
  // --------------------
  // The record in the output register still holds its credit, so it
  // is set aside before a new grant
  assign credit_avail = (credit_q > CreditW'(trace_valid_q));

  always_comb begin
    credit_d = credit_q + CreditW'(credit_return_i) - CreditW'(trace_valid_q);
  end

  // --------------------
  // Arbitration
  // --------------------
  // Search starts one past the last granted port
  always_comb begin
    int idx;
    gnt_valid = 1'b0;
    gnt_idx   = last_q;
    for (int off = 1; off <= NrPorts; off++) begin
      idx = (int'(last_q) + off) % NrPorts;
      if (!gnt_valid && not_empty_i[idx]) begin
        gnt_valid = 1'b1;
        gnt_idx   = idx[`PORT_IDX_W-1:0];
      end
    end
  end

  assign grant = gnt_valid & credit_avail;

  always_comb begin
    pop_o = '0;
    if (grant) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  // --------------------
  // State and output
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q      <= CreditW'(`TRACE_CREDITS);
      last_q        <= '0;
      trace_valid_q <= 1'b0;
    end else begin
      credit_q      <= credit_d;
      trace_valid_q <= grant;
      if (grant) last_q <= gnt_idx;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      trace_q <= rec_i[gnt_idx];
    end
  end

  assign trace_o       = trace_q;
  assign trace_valid_o = trace_valid_q;
  // Any queue that dropped a record
  assign overflow_o    = |overflow_i;

endmodule

/* commit_trace.sv */
// Top level of the commit trace monitor: classify stage, per-port queues and merge
`timescale 1ns/1ps
`include "commit_trace_defines.svh"

module commit_trace (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  commit_pkg::commit_bus_t commit_i,
  input  commit_pkg::commit_ack_t commit_ack_i,
  input  logic                    credit_return_i,
  output trace_pkg::trace_rec_t   trace_o,
  output logic                    trace_valid_o,
  output trace_pkg::cfi_flags_t   cfi_o,
  output logic                    overflow_o
);

  // Classify to queues
  logic [`NR_COMMIT_PORTS-1:0]                  push;
  trace_pkg::trace_rec_t [`NR_COMMIT_PORTS-1:0] cls_rec;
  // Queues to merge
  logic [`NR_COMMIT_PORTS-1:0]                  pop, not_empty, q_overflow;
  trace_pkg::trace_rec_t [`NR_COMMIT_PORTS-1:0] q_rec;

  commit_classify i_commit_classify (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_i     ),
    .commit_ack_i ( commit_ack_i ),
    .push_o       ( push         ),
    .rec_o        ( cls_rec      ),
    .cfi_o        ( cfi_o        )
  );

  // One queue per commit port
  for (genvar i = 0; i < `NR_COMMIT_PORTS; i++) begin : gen_queue
    trace_queue #(
      .Depth ( `TRACE_QUEUE_DEPTH )
    ) i_trace_queue (
      .clk_i       ( clk_i         ),
      .rst_ni      ( rst_ni        ),
      .push_i      ( push[i]       ),
      .rec_i       ( cls_rec[i]    ),
      .pop_i       ( pop[i]        ),
      .rec_o       ( q_rec[i]      ),
      .not_empty_o ( not_empty[i]  ),
      .overflow_o  ( q_overflow[i] )
    );
  end

  trace_merge i_trace_merge (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .rec_i           ( q_rec           ),
    .not_empty_i     ( not_empty       ),
    .overflow_i      ( q_overflow      ),
    .pop_o           ( pop             ),
    .credit_return_i ( credit_return_i ),
    .trace_o         ( trace_o         ),
    .trace_valid_o   ( trace_valid_o   ),
    .overflow_o      ( overflow_o      )
  );

endmodule

/* commit_trace_asserts.sv */
// Bound assertions on credits and trace valid of the commit trace top level
`timescale 1ns/1ps
`include "commit_trace_defines.svh"

module commit_trace_asserts #(
  parameter int unsigned CreditW = $clog2(`TRACE_CREDITS + 1)
) (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               trace_valid_i,
  input logic [CreditW-1:0] credit_i
);

  // Failed assertions so far
  int unsigned fail_cnt = 0;

  // A record on the output still holds its credit
  valid_needs_credit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) trace_valid_i |-> (credit_i != '0)
  ) else begin
    fail_cnt++;
    $error("trace_valid_o high while the credit counter is zero");
  end

  credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) credit_i <= CreditW'(`TRACE_CREDITS)
  ) else begin
    fail_cnt++;
    $error("credit counter above the credits granted after reset");
  end

  // First cycle out of reset
  quiet_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |=> !trace_valid_i
  ) else begin
    fail_cnt++;
    $error("trace_valid_o high in the cycle after reset release");
  end

endmodule

bind commit_trace commit_trace_asserts i_commit_trace_asserts (
  .clk_i         ( clk_i                  ),
  .rst_ni        ( rst_ni                 ),
  .trace_valid_i ( trace_valid_o          ),
  .credit_i      ( i_trace_merge.credit_q )
);

/* commit_trace_tb.sv */
// Testbench for the commit trace monitor with stimulus table, credit consumer and checks
`timescale 1ns/1ps
`include "commit_trace_defines.svh"

module commit_trace_tb;

  // One table row, applied for one cycle
  typedef struct packed {
    logic                    sync;
    logic                    pause;
    commit_pkg::commit_ack_t ack;
    commit_pkg::commit_ack_t drop;
    commit_pkg::commit_bus_t bus;
  } stim_row_t;

  localparam logic [`INSN_W-1:0] Nop   = 32'h00000013;
  localparam logic [`INSN_W-1:0] Jalr  = 32'h000080e7;
  localparam logic [`INSN_W-1:0] Ret   = 32'h00008067;
  localparam logic [`INSN_W-1:0] Addi  = 32'h00100093;
  localparam logic [`INSN_W-1:0] Ecall = 32'h00000073;
  localparam logic [`XLEN-1:0]   IrqTimer = {1'b1, (`XLEN-1)'(7)};
  localparam int unsigned        IdleTimeout = 200;

  logic                    clk_i;
  logic                    rst_ni;
  commit_pkg::commit_bus_t commit_i;
  commit_pkg::commit_ack_t commit_ack_i;
  logic                    credit_return_i;
  trace_pkg::trace_rec_t   trace_o;
  logic                    trace_valid_o;
  trace_pkg::cfi_flags_t   cfi_o;
  logic                    overflow_o;

  stim_row_t               table_q [$];
  trace_pkg::trace_rec_t   exp_q [`NR_COMMIT_PORTS][$];
  trace_pkg::cfi_flags_t   exp_cfi;
  commit_pkg::commit_ack_t drop_mask;
  logic                    pause;
  logic                    exp_overflow;
  int unsigned             cycle_cnt;
  int unsigned             paused_recs;
  // Cycle from which each outstanding credit may be returned
  int unsigned             due_q [$];

  commit_trace i_commit_trace (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .commit_i        ( commit_i        ),
    .commit_ack_i    ( commit_ack_i    ),
    .credit_return_i ( credit_return_i ),
    .trace_o         ( trace_o         ),
    .trace_valid_o   ( trace_valid_o   ),
    .cfi_o           ( cfi_o           ),
    .overflow_o      ( overflow_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------
  // Reference rules
  // --------------------
  function automatic commit_pkg::commit_entry_t make_entry(input logic [`XLEN-1:0] pc,
      input logic [`INSN_W-1:0] insn, input logic ex_valid, input logic [`XLEN-1:0] cause);
    commit_pkg::commit_entry_t e;
    e.pc       = pc;
    e.insn     = insn;
    e.ex_valid = ex_valid;
    e.cause    = cause;
    return e;
  endfunction

  function automatic trace_pkg::trace_rec_t expected_rec(input int port,
      input commit_pkg::commit_entry_t e);
    trace_pkg::trace_rec_t r;
    r.port  = port[`PORT_IDX_W-1:0];
    r.pc    = e.pc;
    r.insn  = e.insn;
    r.cause = e.cause;
    if (!e.ex_valid) r.kind = trace_pkg::TRACE_RETIRE;
    else if (e.cause[`XLEN-1]) r.kind = trace_pkg::TRACE_INTERRUPT;
    else r.kind = trace_pkg::TRACE_EXCEPTION;
    return r;
  endfunction

  // JALR opcode and canonical NOP, retired entries only
  function automatic trace_pkg::cfi_flags_t expected_cfi(input commit_pkg::commit_bus_t bus,
      input commit_pkg::commit_ack_t ack);
    trace_pkg::cfi_flags_t f;
    f = '0;
    for (int i = 0; i < `NR_COMMIT_PORTS; i++) begin
      if (ack[i] && !bus[i].ex_valid) begin
        f.jalr[i] = (bus[i].insn[6:0] == 7'b1100111);
        f.nop[i]  = (bus[i].insn == 32'h00000013);
      end
    end
    return f;
  endfunction

  // --------------------
  // Checks
  // --------------------
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_rec(input string name, input trace_pkg::trace_rec_t got,
      input trace_pkg::trace_rec_t exp);
    if (got !== exp) stop_run($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_cfi(input string name, input trace_pkg::cfi_flags_t got,
      input trace_pkg::cfi_flags_t exp);
    if (got !== exp) stop_run($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) stop_run($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Monitor and consumer side, sampled mid-cycle
  initial begin
    trace_pkg::trace_rec_t exp_rec;
    void'($urandom(32'hcdbf));
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        check_cfi("cfi_o", cfi_o, exp_cfi);
        if (trace_valid_o) begin
          if (exp_q[trace_o.port].size() == 0) begin
            stop_run($sformatf("Unexpected record on port %0d", trace_o.port));
          end else begin
            exp_rec = exp_q[trace_o.port].pop_front();
            check_rec("trace_o", trace_o, exp_rec);
          end
          due_q.push_back(cycle_cnt + ($urandom % 4));
          if (pause) paused_recs++;
        end
        exp_cfi = expected_cfi(commit_i, commit_ack_i);
        for (int i = 0; i < `NR_COMMIT_PORTS; i++) begin
          if (commit_ack_i[i] && !drop_mask[i]) exp_q[i].push_back(expected_rec(i, commit_i[i]));
        end
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic add_row(input logic sync, input logic hold, input commit_pkg::commit_ack_t ack,
      input commit_pkg::commit_ack_t drop, input commit_pkg::commit_entry_t e0,
      input commit_pkg::commit_entry_t e1);
    stim_row_t row;
    row.sync   = sync;
    row.pause  = hold;
    row.ack    = ack;
    row.drop   = drop;
    row.bus[0] = e0;
    row.bus[1] = e1;
    table_q.push_back(row);
  endtask

  task automatic build_table();
    commit_pkg::commit_entry_t idle;
    idle = make_entry('0, Nop, 1'b0, '0);
    // Each kind, plus JALR and NOP entries that must not pulse cfi_o
    add_row(0, 0, 2'b11, 2'b00, make_entry(64'h8000_0000, Addi, 0, '0),
            make_entry(64'h8000_0004, Jalr, 0, '0));
    add_row(0, 0, 2'b01, 2'b00, make_entry(64'h8000_0008, Nop, 0, '0),
            make_entry(64'h8000_000c, Jalr, 0, '0));
    add_row(0, 0, 2'b11, 2'b00, make_entry(64'h8000_0010, Ecall, 1, 64'd11),
            make_entry(64'h8000_0014, Addi, 1, IrqTimer));
    add_row(0, 0, 2'b11, 2'b00, make_entry(64'h8000_0018, Jalr, 1, 64'd1),
            make_entry(64'h8000_001c, Nop, 0, '0));
    add_row(0, 0, 2'b10, 2'b00, make_entry(64'h8000_0020, Nop, 0, '0),
            make_entry(64'h8000_0024, Nop, 1, IrqTimer));
    add_row(0, 0, 2'b00, 2'b00, idle, idle);
    add_row(0, 0, 2'b11, 2'b00, make_entry(64'h8000_0028, Ret, 0, '0),
            make_entry(64'h8000_002c, Nop, 0, '0));
    // Both ports back to back
    for (int k = 0; k < 5; k++) begin
      add_row(k == 0, 0, 2'b11, 2'b00,
              make_entry(64'h9000_0000 + 8 * k, (k % 2) ? Nop : Addi, 0, '0),
              make_entry(64'ha000_0000 + 8 * k, Jalr, k == 2 || k == 4,
                         (k == 4) ? IrqTimer : 64'd2));
    end
    // Credits held back, port 1 spends all of them
    for (int k = 0; k < 4; k++) begin
      add_row(k == 0, 1, 2'b10, 2'b00, idle, make_entry(64'hb000_0000 + 4 * k, Addi, 0, '0));
    end
    for (int k = 0; k < 4; k++) begin
      add_row(0, 1, 2'b00, 2'b00, idle, idle);
    end
    // Port 0 overruns its queue, the last two are lost
    for (int k = 0; k < `TRACE_QUEUE_DEPTH + 2; k++) begin
      add_row(0, 1, 2'b01, (k >= `TRACE_QUEUE_DEPTH) ? 2'b01 : 2'b00,
              make_entry(64'hc000_0000 + 4 * k, Nop, 0, '0), idle);
    end
    for (int k = 0; k < 4; k++) begin
      add_row(0, 1, 2'b00, 2'b00, idle, idle);
    end
    add_row(0, 0, 2'b00, 2'b00, idle, idle);
  endtask

  // Next cycle, inputs change 1 ns after the edge
  task automatic tick();
    @(posedge clk_i);
    #1;
    cycle_cnt++;
    credit_return_i = 1'b0;
    if (!pause && due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
      void'(due_q.pop_front());
      credit_return_i = 1'b1;
    end
  endtask

  task automatic wait_idle(input string what);
    int unsigned n;
    n = 0;
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || due_q.size() != 0) begin
      tick();
      n++;
      if (n > IdleTimeout) stop_run($sformatf("Timeout waiting for %s", what));
    end
  endtask

  initial begin
    rst_ni          = 1'b0;
    commit_i        = '0;
    commit_ack_i    = '0;
    credit_return_i = 1'b0;
    drop_mask       = '0;
    pause           = 1'b0;
    exp_cfi         = '0;
    exp_overflow    = 1'b0;
    cycle_cnt       = 0;
    paused_recs     = 0;
    build_table();
    repeat (10) tick();
    rst_ni = 1'b1;
    tick();
    check_bit("trace_valid_o", trace_valid_o, 1'b0);
    check_cfi("cfi_o", cfi_o, '0);
    check_bit("overflow_o", overflow_o, 1'b0);

    foreach (table_q[r]) begin
      tick();
      if (table_q[r].sync) begin
        commit_ack_i = '0;
        drop_mask    = '0;
        wait_idle("records and credits to drain");
        check_bit("overflow_o", overflow_o, exp_overflow);
      end
      if (pause && !table_q[r].pause) begin
        if (paused_recs > `TRACE_CREDITS) stop_run("More records than credits while paused");
        paused_recs = 0;
      end
      pause        = table_q[r].pause;
      commit_i     = table_q[r].bus;
      commit_ack_i = table_q[r].ack;
      drop_mask    = table_q[r].drop;
      if (|(table_q[r].ack & table_q[r].drop)) exp_overflow = 1'b1;
    end

    tick();
    commit_ack_i = '0;
    drop_mask    = '0;
    wait_idle("the last records and credits");
    check_bit("overflow_o", overflow_o, exp_overflow);
    if (i_commit_trace.i_commit_trace_asserts.fail_cnt == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("Bound assertions on the top level failed");
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped after assertion errors");
    end
  end

endmodule

/* commit_trace.f */
+incdir+.
commit_pkg.sv
trace_pkg.sv
commit_classify.sv
trace_queue.sv
trace_merge.sv
commit_trace.sv
commit_trace_asserts.sv
commit_trace_tb.sv

/* Bender.yml */
package:
  name: commit_trace

export_include_dirs:
  - .

sources:
  - files:
      - commit_pkg.sv
      - trace_pkg.sv
      - commit_classify.sv
      - trace_queue.sv
      - trace_merge.sv
      - commit_trace.sv
  - target: test
    files:
      - commit_trace_asserts.sv
      - commit_trace_tb.sv
